// ==== logic/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

  // ---------------------------------------------------------------------------
  // address and PTE widths for Sv32
  // ---------------------------------------------------------------------------
  localparam int unsigned VADDR_W        = 32;
  localparam int unsigned PADDR_W        = 34;
  localparam int unsigned PPN_W          = 22;
  localparam int unsigned VPN_W          = 10;
  localparam int unsigned PTE_WORD_W     = 32;
  localparam int unsigned PAGE_OFFSET_W  = 12;
  // bytes per PTE in the page table
  localparam int unsigned PTE_BYTES      = 4;

  typedef logic [VADDR_W-1:0]    vaddr_t;
  typedef logic [PADDR_W-1:0]    paddr_t;
  typedef logic [PPN_W-1:0]      ppn_t;
  typedef logic [VPN_W-1:0]      vpn_part_t;
  typedef logic [PTE_WORD_W-1:0] pte_t;

  // PTE flag bits with the PPN in the upper 22 bits
  localparam int unsigned PTE_V       = 0;
  localparam int unsigned PTE_R       = 1;
  localparam int unsigned PTE_W       = 2;
  localparam int unsigned PTE_X       = 3;
  localparam int unsigned PTE_U       = 4;
  localparam int unsigned PTE_A       = 6;
  localparam int unsigned PTE_D       = 7;
  localparam int unsigned PTE_PPN_LSB = 10;

  // ---------------------------------------------------------------------------
  // privilege and exception causes
  // ---------------------------------------------------------------------------
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01
  } priv_lvl_t;

  typedef logic [3:0] exc_cause_t;

  localparam exc_cause_t CAUSE_LD_ACCESS = 4'd5;
  localparam exc_cause_t CAUSE_ST_ACCESS = 4'd7;
  localparam exc_cause_t CAUSE_LD_PAGE   = 4'd13;
  localparam exc_cause_t CAUSE_ST_PAGE   = 4'd15;

  // ---------------------------------------------------------------------------
  // walker FSM and sizes
  // ---------------------------------------------------------------------------
  typedef enum logic [1:0] {
    WALK_IDLE,
    WALK_REQ,
    WALK_WAIT,
    WALK_DONE
  } walk_state_t;

  localparam int unsigned DTLB_ENTRIES        = 4;
  localparam int unsigned DTLB_PTR_W          = $clog2(DTLB_ENTRIES);
  // cycles allowed for one page table read
  localparam int unsigned WALK_TIMEOUT_CYCLES = 31;
  localparam int unsigned TIMER_W             = 5;

endpackage

`default_nettype wire

// ==== logic/sv32_dtlb.sv ====
`default_nettype none
`timescale 1ns/1ns

module sv32_dtlb
  import mmu_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   flush_i,
  input  vaddr_t lookup_vaddr_i,
  input  logic   fill_i,
  input  vaddr_t fill_vaddr_i,
  input  pte_t   fill_pte_i,
  input  logic   fill_is_mega_i,
  output logic   hit_o,
  output pte_t   hit_pte_o,
  output logic   hit_is_mega_o
);

  // per-entry tag, flags and cached leaf PTE
  logic      [DTLB_ENTRIES-1:0] valid_q;
  logic      [DTLB_ENTRIES-1:0] mega_q;
  vpn_part_t                    vpn1_q [DTLB_ENTRIES];
  vpn_part_t                    vpn0_q [DTLB_ENTRIES];
  pte_t                         pte_q  [DTLB_ENTRIES];

  // next entry to replace
  logic      [DTLB_PTR_W-1:0]   victim_q;

  logic      [DTLB_ENTRIES-1:0] match;
  vpn_part_t                    lu_vpn1;
  vpn_part_t                    lu_vpn0;

  assign lu_vpn1 = lookup_vaddr_i[PAGE_OFFSET_W+VPN_W +: VPN_W];
  assign lu_vpn0 = lookup_vaddr_i[PAGE_OFFSET_W +: VPN_W];

  // ---------------------------------------------------------------------------
  // lookup
  // ---------------------------------------------------------------------------
  always_comb begin
    hit_pte_o     = '0;
    hit_is_mega_o = 1'b0;
    for (int i = 0; i < DTLB_ENTRIES; i++) begin
      // megapage entries ignore vpn0
      match[i] = valid_q[i] && (vpn1_q[i] == lu_vpn1) &&
                 (mega_q[i] || (vpn0_q[i] == lu_vpn0));
      if (match[i]) begin
        hit_pte_o     = pte_q[i];
        hit_is_mega_o = mega_q[i];
      end
    end
  end

  assign hit_o = |match;

  // ---------------------------------------------------------------------------
  // fill and flush
  // ---------------------------------------------------------------------------
  // flush wins over a fill in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_i) begin
      valid_q[victim_q] <= 1'b1;
      // round robin over all entries
      victim_q          <= victim_q + DTLB_PTR_W'(1);
    end
  end

  // tag and PTE storage
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      vpn1_q[victim_q] <= fill_vaddr_i[PAGE_OFFSET_W+VPN_W +: VPN_W];
      vpn0_q[victim_q] <= fill_vaddr_i[PAGE_OFFSET_W +: VPN_W];
      pte_q[victim_q]  <= fill_pte_i;
      mega_q[victim_q] <= fill_is_mega_i;
    end
  end

  // a fill only follows a miss, so two entries never cover one page
  a_single_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(match));

endmodule

`default_nettype wire

// ==== logic/sv32_ptw.sv ====
`default_nettype none
`timescale 1ns/1ns

module sv32_ptw
  import mmu_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   start_i,
  input  vaddr_t vaddr_i,
  input  ppn_t   satp_ppn_i,
  input  logic   mem_rvalid_i,
  input  pte_t   mem_rdata_i,
  input  logic   timer_expired_i,
  output logic   busy_o,
  output logic   mem_req_o,
  output paddr_t mem_addr_o,
  output logic   timer_start_o,
  output logic   timer_stop_o,
  output logic   done_o,
  output pte_t   leaf_pte_o,
  output logic   leaf_is_mega_o,
  output logic   page_fault_o,
  output logic   access_fault_o,
  output logic   fill_o
);

  walk_state_t state_q, state_d;
  // high while reading the level-1 PTE
  logic        level_q, level_d;
  logic        page_fault_q, page_fault_d;
  logic        access_fault_q, access_fault_d;
  ppn_t        ppn_q, ppn_d;
  pte_t        leaf_pte_q, leaf_pte_d;
  logic        mega_q, mega_d;

  ppn_t        base_ppn;
  vpn_part_t   vpn_sel;
  logic        pte_invalid;
  logic        pte_leaf;
  logic        pte_misaligned;

  // ---------------------------------------------------------------------------
  // PTE address
  // ---------------------------------------------------------------------------
  // first read goes out straight from idle and the level-0 read from WALK_REQ
  assign base_ppn = (state_q == WALK_IDLE) ? satp_ppn_i : ppn_q;
  assign vpn_sel  = (state_q == WALK_IDLE) ? vaddr_i[PAGE_OFFSET_W+VPN_W +: VPN_W]
                                           : vaddr_i[PAGE_OFFSET_W +: VPN_W];
  assign mem_addr_o = paddr_t'({base_ppn, {PAGE_OFFSET_W{1'b0}}}) +
                      paddr_t'(vpn_sel) * paddr_t'(PTE_BYTES);

  assign mem_req_o     = ((state_q == WALK_IDLE) && start_i) || (state_q == WALK_REQ);
  assign timer_start_o = mem_req_o;
  assign timer_stop_o  = (state_q == WALK_WAIT) && mem_rvalid_i;

  // W without R is a reserved encoding
  assign pte_invalid    = !mem_rdata_i[PTE_V] || (mem_rdata_i[PTE_W] && !mem_rdata_i[PTE_R]);
  assign pte_leaf       = mem_rdata_i[PTE_R] || mem_rdata_i[PTE_X];
  // megapage needs PPN[0] zero
  assign pte_misaligned = |mem_rdata_i[PTE_PPN_LSB +: VPN_W];

  // ---------------------------------------------------------------------------
  // walk FSM
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d        = state_q;
    level_d        = level_q;
    page_fault_d   = page_fault_q;
    access_fault_d = access_fault_q;
    ppn_d          = ppn_q;
    leaf_pte_d     = leaf_pte_q;
    mega_d         = mega_q;
    case (state_q)
      WALK_IDLE: begin
        if (start_i) begin
          state_d        = WALK_WAIT;
          level_d        = 1'b1;
          page_fault_d   = 1'b0;
          access_fault_d = 1'b0;
        end
      end
      WALK_REQ: begin
        state_d = WALK_WAIT;
      end
      WALK_WAIT: begin
        // a response in the expiry cycle still counts
        if (mem_rvalid_i) begin
          state_d = WALK_DONE;
          if (pte_invalid) begin
            page_fault_d = 1'b1;
          end else if (pte_leaf) begin
            if (level_q && pte_misaligned) begin
              page_fault_d = 1'b1;
            end else begin
              leaf_pte_d = mem_rdata_i;
              mega_d     = level_q;
            end
          end else if (level_q) begin
            // pointer to the next level
            ppn_d   = mem_rdata_i[PTE_WORD_W-1:PTE_PPN_LSB];
            level_d = 1'b0;
            state_d = WALK_REQ;
          end else begin
            // pointer at level 0 with no levels left
            page_fault_d = 1'b1;
          end
        end else if (timer_expired_i) begin
          state_d        = WALK_DONE;
          access_fault_d = 1'b1;
        end
      end
      WALK_DONE: begin
        state_d = WALK_IDLE;
      end
      default: begin
        state_d = WALK_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= WALK_IDLE;
      level_q        <= 1'b1;
      page_fault_q   <= 1'b0;
      access_fault_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      level_q        <= level_d;
      page_fault_q   <= page_fault_d;
      access_fault_q <= access_fault_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ppn_q      <= ppn_d;
    leaf_pte_q <= leaf_pte_d;
    mega_q     <= mega_d;
  end

  // outputs
  assign busy_o         = start_i || (state_q != WALK_IDLE);
  assign done_o         = (state_q == WALK_DONE);
  assign fill_o         = done_o && !page_fault_q && !access_fault_q;
  assign leaf_pte_o     = leaf_pte_q;
  assign leaf_is_mega_o = mega_q;
  assign page_fault_o   = page_fault_q;
  assign access_fault_o = access_fault_q;

  // memory answers only the read this walker has outstanding
  a_rvalid_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> (state_q == WALK_WAIT));

endmodule

`default_nettype wire

// ==== logic/walk_timer.sv ====
`default_nettype none
`timescale 1ns/1ns

module walk_timer
  import mmu_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic stop_i,
  output logic expired_o
);

  logic [TIMER_W-1:0] cnt_q;
  logic               running_q;

  // cnt_q equals the cycles elapsed since the read went out
  assign expired_o = running_q && (cnt_q == TIMER_W'(WALK_TIMEOUT_CYCLES));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      running_q <= 1'b0;
    end else if (start_i) begin
      cnt_q     <= TIMER_W'(1);
      running_q <= 1'b1;
    end else if (stop_i || expired_o) begin
      // single pulse, then idle until the next read
      running_q <= 1'b0;
    end else if (running_q) begin
      cnt_q <= cnt_q + TIMER_W'(1);
    end
  end

endmodule

`default_nettype wire

// ==== logic/sv32_perm_check.sv ====
`default_nettype none
`timescale 1ns/1ns

module sv32_perm_check
  import mmu_pkg::*;
(
  input  pte_t       pte_i,
  input  logic       is_store_i,
  input  priv_lvl_t  priv_lvl_i,
  input  logic       sum_i,
  output logic       fault_o,
  output exc_cause_t cause_o
);

  logic priv_fault;
  logic rw_fault;
  logic accessed_fault;

  // ---------------------------------------------------------------------------
  // privilege
  // ---------------------------------------------------------------------------
  // user code may only touch U pages
  // supervisor touches U pages only with SUM set
  assign priv_fault = ((priv_lvl_i == PRIV_U) && !pte_i[PTE_U]) ||
                      ((priv_lvl_i == PRIV_S) && pte_i[PTE_U] && !sum_i);

  // ---------------------------------------------------------------------------
  // access type
  // ---------------------------------------------------------------------------
  // stores also need D, hardware does not update it
  assign rw_fault = is_store_i ? (!pte_i[PTE_W] || !pte_i[PTE_D])
                               : !pte_i[PTE_R];

  // A clear is a fault, software manages the bit
  assign accessed_fault = !pte_i[PTE_A];

  assign fault_o = accessed_fault || priv_fault || rw_fault;

  // only page faults come from here
  assign cause_o = is_store_i ? CAUSE_ST_PAGE : CAUSE_LD_PAGE;

endmodule

`default_nettype wire

// ==== logic/sv32_mmu.sv ====
`default_nettype none
`timescale 1ns/1ns

module sv32_mmu
  import mmu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  vaddr_t     vaddr_i,
  input  logic       is_store_i,
  input  priv_lvl_t  priv_lvl_i,
  input  logic       sum_i,
  input  logic       translation_en_i,
  input  ppn_t       satp_ppn_i,
  input  logic       flush_i,
  input  logic       mem_rvalid_i,
  input  pte_t       mem_rdata_i,
  output logic       valid_o,
  output paddr_t     paddr_o,
  output logic       exc_valid_o,
  output exc_cause_t exc_cause_o,
  output logic       busy_o,
  output logic       mem_req_o,
  output paddr_t     mem_addr_o
);

  // request stage
  logic       req_q;
  vaddr_t     vaddr_q;
  logic       is_store_q;
  priv_lvl_t  priv_lvl_q;
  logic       sum_q;
  logic       xlate_q;
  ppn_t       satp_ppn_q;
  logic       hit_q;
  pte_t       hit_pte_q;
  logic       hit_mega_q;

  // DTLB lookup for the incoming vaddr
  logic       dtlb_hit;
  pte_t       dtlb_pte;
  logic       dtlb_mega;

  // walker and timer
  logic       walk_start;
  logic       walk_done;
  logic       walk_fill;
  pte_t       walk_pte;
  logic       walk_mega;
  logic       walk_page_fault;
  logic       walk_access_fault;
  logic       timer_start;
  logic       timer_stop;
  logic       timer_expired;

  // result path
  logic       hit_valid;
  pte_t       sel_pte;
  logic       sel_mega;
  logic       perm_fault;
  exc_cause_t perm_cause;

  // ---------------------------------------------------------------------------
  // request stage register
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_i;
    end
  end

  // attributes stay put through a walk since no strobe comes while busy
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      vaddr_q    <= vaddr_i;
      is_store_q <= is_store_i;
      priv_lvl_q <= priv_lvl_i;
      sum_q      <= sum_i;
      xlate_q    <= translation_en_i;
      satp_ppn_q <= satp_ppn_i;
      hit_q      <= dtlb_hit;
      hit_pte_q  <= dtlb_pte;
      hit_mega_q <= dtlb_mega;
    end
  end

  sv32_dtlb i_dtlb (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .lookup_vaddr_i (vaddr_i),
    .fill_i         (walk_fill),
    .fill_vaddr_i   (vaddr_q),
    .fill_pte_i     (walk_pte),
    .fill_is_mega_i (walk_mega),
    .hit_o          (dtlb_hit),
    .hit_pte_o      (dtlb_pte),
    .hit_is_mega_o  (dtlb_mega)
  );

  // miss in the stage starts the walk in the same cycle
  assign walk_start = req_q && xlate_q && !hit_q;
  assign hit_valid  = req_q && xlate_q && hit_q;

  sv32_ptw i_ptw (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .start_i         (walk_start),
    .vaddr_i         (vaddr_q),
    .satp_ppn_i      (satp_ppn_q),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .timer_expired_i (timer_expired),
    .busy_o          (busy_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .timer_start_o   (timer_start),
    .timer_stop_o    (timer_stop),
    .done_o          (walk_done),
    .leaf_pte_o      (walk_pte),
    .leaf_is_mega_o  (walk_mega),
    .page_fault_o    (walk_page_fault),
    .access_fault_o  (walk_access_fault),
    .fill_o          (walk_fill)
  );

  walk_timer i_walk_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (timer_start),
    .stop_i    (timer_stop),
    .expired_o (timer_expired)
  );

  // ---------------------------------------------------------------------------
  // result selection
  // ---------------------------------------------------------------------------
  // hit and walk completion never coincide
  assign sel_pte  = walk_done ? walk_pte : hit_pte_q;
  assign sel_mega = walk_done ? walk_mega : hit_mega_q;

  sv32_perm_check i_perm_check (
    .pte_i      (sel_pte),
    .is_store_i (is_store_q),
    .priv_lvl_i (priv_lvl_q),
    .sum_i      (sum_q),
    .fault_o    (perm_fault),
    .cause_o    (perm_cause)
  );

  assign valid_o = (req_q && !xlate_q) || hit_valid || walk_done;

  always_comb begin
    if (!xlate_q) begin
      // bare mode zero-extends the vaddr
      paddr_o = paddr_t'(vaddr_q);
    end else begin
      paddr_o = {sel_pte[PTE_WORD_W-1:PTE_PPN_LSB], vaddr_q[PAGE_OFFSET_W-1:0]};
      // megapage keeps vpn0 from the vaddr
      if (sel_mega) begin
        paddr_o[PAGE_OFFSET_W +: VPN_W] = vaddr_q[PAGE_OFFSET_W +: VPN_W];
      end
    end
  end

  always_comb begin
    exc_valid_o = 1'b0;
    exc_cause_o = perm_cause;
    if (xlate_q) begin
      if (walk_done && walk_access_fault) begin
        exc_valid_o = 1'b1;
        exc_cause_o = is_store_q ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS;
      end else if (walk_done && walk_page_fault) begin
        exc_valid_o = 1'b1;
        exc_cause_o = is_store_q ? CAUSE_ST_PAGE : CAUSE_LD_PAGE;
      end else begin
        exc_valid_o = perm_fault;
      end
    end
  end

  // requester holds off while a walk runs
  a_no_req_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !busy_o);

endmodule

`default_nettype wire

// ==== verif/pt_mem_model.sv ====
`default_nettype none
`timescale 1ns/1ns

module pt_mem_model
  import mmu_pkg::*;
#(
  // reads at or above this PPN never get an answer
  parameter ppn_t DEAD_PPN = 22'h3F0000
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   req_i,
  input  paddr_t addr_i,
  output logic   rvalid_o,
  output pte_t   rdata_o
);

  // sparse page table contents, unwritten words read as zero
  pte_t        table_q [paddr_t];

  logic        pending_q;
  paddr_t      addr_q;
  int unsigned delay_q;
  logic        rvalid_q = 1'b0;
  pte_t        rdata_q  = '0;

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // backdoor write from the testbench
  task automatic load_pte(input paddr_t addr, input pte_t data);
    table_q[addr] = data;
  endtask

  // ---------------------------------------------------------------------------
  // read port, 1 to 4 cycles of latency
  // ---------------------------------------------------------------------------
  // runs on the falling edge so the MMU sees stable inputs at its rising edge
  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      addr_q    <= '0;
      delay_q   <= 0;
      rvalid_q  <= 1'b0;
      rdata_q   <= '0;
    end else begin
      rvalid_q <= 1'b0;
      if (req_i && (addr_i[PADDR_W-1:PAGE_OFFSET_W] < DEAD_PPN)) begin
        pending_q <= 1'b1;
        addr_q    <= addr_i;
        delay_q   <= $urandom_range(3, 0);
      end else if (pending_q) begin
        if (delay_q == 0) begin
          pending_q <= 1'b0;
          rvalid_q  <= 1'b1;
          rdata_q   <= table_q.exists(addr_q) ? table_q[addr_q] : '0;
        end else begin
          delay_q <= delay_q - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_sv32_mmu.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_sv32_mmu
  import mmu_pkg::*;
();

  // root table, level-0 table and the unanswered region
  localparam ppn_t        SATP_PPN   = 22'h00100;
  localparam ppn_t        L0_PPN     = 22'h00200;
  localparam ppn_t        DEAD_PPN   = 22'h3F0000;
  localparam int unsigned VALID_WAIT = 100;

  // Sv32 PTE layout as used by the reference walk
  localparam int unsigned BIT_V = 0;
  localparam int unsigned BIT_R = 1;
  localparam int unsigned BIT_W = 2;
  localparam int unsigned BIT_X = 3;
  localparam int unsigned BIT_U = 4;
  localparam int unsigned BIT_A = 6;
  localparam logic [7:0]  F_R   = 8'(1 << BIT_R);
  localparam logic [7:0]  F_W   = 8'(1 << BIT_W);
  localparam logic [7:0]  F_U   = 8'(1 << BIT_U);
  localparam logic [7:0]  F_A   = 8'(1 << BIT_A);
  localparam logic [7:0]  F_D   = 8'h80;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       req;
  vaddr_t     vaddr;
  logic       is_store;
  priv_lvl_t  priv_lvl;
  logic       sum;
  logic       xlate_en;
  ppn_t       satp_ppn;
  logic       flush;
  logic       mem_rvalid;
  pte_t       mem_rdata;
  logic       valid;
  paddr_t     paddr;
  logic       exc_valid;
  exc_cause_t exc_cause;
  logic       busy;
  logic       mem_req;
  paddr_t     mem_addr;

  // expected result of the request in flight
  string       test_name = "reset";
  paddr_t      exp_paddr = '0;
  logic        exp_exc   = 1'b0;
  exc_cause_t  exp_cause = '0;
  logic        exp_fast  = 1'b0;
  // level-1 PTE address of the first walk read
  paddr_t      exp_l1_addr  = '0;
  int unsigned mem_req_cnt  = 0;
  int unsigned mem_req_base = 0;

  // reference copy of the page table
  pte_t pt_ref [paddr_t];

  always #4 clk = ~clk;

  sv32_mmu i_sv32_mmu (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .req_i            (req),
    .vaddr_i          (vaddr),
    .is_store_i       (is_store),
    .priv_lvl_i       (priv_lvl),
    .sum_i            (sum),
    .translation_en_i (xlate_en),
    .satp_ppn_i       (satp_ppn),
    .flush_i          (flush),
    .mem_rvalid_i     (mem_rvalid),
    .mem_rdata_i      (mem_rdata),
    .valid_o          (valid),
    .paddr_o          (paddr),
    .exc_valid_o      (exc_valid),
    .exc_cause_o      (exc_cause),
    .busy_o           (busy),
    .mem_req_o        (mem_req),
    .mem_addr_o       (mem_addr)
  );

  pt_mem_model #(
    .DEAD_PPN (DEAD_PPN)
  ) i_pt_mem (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .req_i    (mem_req),
    .addr_i   (mem_addr),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

  // page table reads issued so far
  always @(negedge clk) begin
    if (mem_req) begin
      mem_req_cnt <= mem_req_cnt + 1;
    end
  end

  task automatic stop_on_error();
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // ---------------------------------------------------------------------------
  // reference translation
  // ---------------------------------------------------------------------------
  function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags | 8'(1 << BIT_V)};
  endfunction

  function automatic paddr_t pte_addr(input ppn_t ppn, input vpn_part_t idx);
    return {ppn, 12'h000} + paddr_t'(idx) * paddr_t'(4);
  endfunction

  task automatic map_pte(input paddr_t addr, input pte_t data);
    pt_ref[addr] = data;
    i_pt_mem.load_pte(addr, data);
  endtask

  function automatic void ref_translate(input vaddr_t va, input logic st,
                                        input priv_lvl_t pv, input logic sm,
                                        output paddr_t pa, output logic exc,
                                        output exc_cause_t cause);
    ppn_t   base;
    paddr_t addr;
    pte_t   p;
    logic   denied;
    base  = SATP_PPN;
    pa    = '0;
    exc   = 1'b1;
    cause = st ? CAUSE_ST_PAGE : CAUSE_LD_PAGE;
    for (int lvl = 1; lvl >= 0; lvl--) begin
      addr = pte_addr(base, va[12+10*lvl +: 10]);
      // read never answered
      if (addr[33:12] >= DEAD_PPN) begin
        cause = st ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS;
        return;
      end
      p = pt_ref.exists(addr) ? pt_ref[addr] : '0;
      if (!p[BIT_V] || (p[BIT_W] && !p[BIT_R])) begin
        return;
      end
      if (p[BIT_R] || p[BIT_X]) begin
        // megapage leaf needs PPN[0] clear
        if ((lvl == 1) && (p[19:10] != '0)) begin
          return;
        end
        denied = !p[BIT_A] ||
                 ((pv == PRIV_U) && !p[BIT_U]) ||
                 ((pv == PRIV_S) && p[BIT_U] && !sm) ||
                 (st ? (!p[BIT_W] || !p[7]) : !p[BIT_R]);
        if (denied) begin
          return;
        end
        pa = {p[31:10], va[11:0]};
        if (lvl == 1) begin
          pa[21:12] = va[21:12];
        end
        exc = 1'b0;
        return;
      end
      base = p[31:10];
    end
    // pointer at level 0 leaves exc set
  endfunction

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  // fast marks a one-cycle result with no page table read
  task automatic translate(input string name, input vaddr_t va, input logic st,
                           input priv_lvl_t pv, input logic sm, input logic en,
                           input logic fast);
    int unsigned cycles;
    @(negedge clk);
    test_name    = name;
    exp_fast     = fast;
    mem_req_base = mem_req_cnt;
    exp_l1_addr  = pte_addr(SATP_PPN, va[31:22]);
    if (en) begin
      ref_translate(va, st, pv, sm, exp_paddr, exp_exc, exp_cause);
    end else begin
      exp_paddr = paddr_t'(va);
      exp_exc   = 1'b0;
      exp_cause = '0;
    end
    req      = 1'b1;
    vaddr    = va;
    is_store = st;
    priv_lvl = pv;
    sum      = sm;
    xlate_en = en;
    @(negedge clk);
    req    = 1'b0;
    cycles = 0;
    while (!valid) begin
      if (cycles == VALID_WAIT) begin
        $display("no valid_o within %0d cycles in test %s", VALID_WAIT, name);
        stop_on_error();
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic flush_dtlb();
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------
  a_fast_result: assert property (@(posedge clk) disable iff (!rst_n)
    (req && exp_fast) |=> valid)
    else begin
      $display("CHECK FAILED %s: valid_o one cycle after req_i expected 1 actual 0",
               test_name);
      stop_on_error();
    end

  a_paddr: assert property (@(posedge clk) disable iff (!rst_n)
    (valid && !exp_exc) |-> (paddr == exp_paddr))
    else begin
      $display("CHECK FAILED %s: paddr_o expected %h actual %h",
               test_name, exp_paddr, $sampled(paddr));
      stop_on_error();
    end

  a_exc_valid: assert property (@(posedge clk) disable iff (!rst_n)
    valid |-> (exc_valid == exp_exc))
    else begin
      $display("CHECK FAILED %s: exc_valid_o expected %b actual %b",
               test_name, exp_exc, $sampled(exc_valid));
      stop_on_error();
    end

  a_exc_cause: assert property (@(posedge clk) disable iff (!rst_n)
    (valid && exp_exc) |-> (exc_cause == exp_cause))
    else begin
      $display("CHECK FAILED %s: exc_cause_o expected %0d actual %0d",
               test_name, exp_cause, $sampled(exc_cause));
      stop_on_error();
    end

  // a hit or bare access never touches memory while a miss always does
  a_mem_traffic: assert property (@(posedge clk) disable iff (!rst_n)
    valid |-> (exp_fast ? (mem_req_cnt == mem_req_base) : (mem_req_cnt != mem_req_base)))
    else begin
      $display("CHECK FAILED %s: page table reads expected %s actual %0d", test_name,
               exp_fast ? "none" : "some", $sampled(mem_req_cnt) - $sampled(mem_req_base));
      stop_on_error();
    end

  // a miss raises busy_o and sends the first read one cycle after the strobe
  a_walk_start: assert property (@(posedge clk) disable iff (!rst_n)
    (req && !exp_fast) |=> (busy && mem_req))
    else begin
      $display("CHECK FAILED %s: busy_o and mem_req_o expected 11 actual %b%b",
               test_name, $sampled(busy), $sampled(mem_req));
      stop_on_error();
    end

  a_l1_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (req && !exp_fast) |=> (mem_addr == exp_l1_addr))
    else begin
      $display("CHECK FAILED %s: mem_addr_o expected %h actual %h",
               test_name, exp_l1_addr, $sampled(mem_addr));
      stop_on_error();
    end

  // busy_o stays up until the walk result
  a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (busy && !valid) |=> busy)
    else begin
      $display("CHECK FAILED %s: busy_o before the result expected 1 actual 0",
               test_name);
      stop_on_error();
    end

  a_busy_release: assert property (@(posedge clk) disable iff (!rst_n)
    valid |=> !busy)
    else begin
      $display("CHECK FAILED %s: busy_o after the result expected 0 actual 1",
               test_name);
      stop_on_error();
    end

  initial begin
    void'($urandom(2391));
    rst_n    = 1'b0;
    req      = 1'b0;
    vaddr    = '0;
    is_store = 1'b0;
    priv_lvl = PRIV_S;
    sum      = 1'b0;
    xlate_en = 1'b0;
    satp_ppn = SATP_PPN;
    flush    = 1'b0;

    // level 1 holds a pointer, a megapage, a misaligned megapage and a dead pointer
    map_pte(pte_addr(SATP_PPN, 10'd1), make_pte(L0_PPN, 8'h00));
    map_pte(pte_addr(SATP_PPN, 10'd2), make_pte(22'h12C00, F_R | F_W | F_A | F_D));
    map_pte(pte_addr(SATP_PPN, 10'd3), make_pte(22'h12C05, F_R | F_W | F_A | F_D));
    map_pte(pte_addr(SATP_PPN, 10'd4), make_pte(DEAD_PPN + 22'h10, 8'h00));
    // level 0 leaves with index 6 unmapped and index 7 pointing further down
    map_pte(pte_addr(L0_PPN, 10'd1), make_pte(22'h2ABCD, F_R | F_W | F_A | F_D));
    map_pte(pte_addr(L0_PPN, 10'd2), make_pte(22'h2AC00, F_R | F_A | F_D));
    map_pte(pte_addr(L0_PPN, 10'd3), make_pte(22'h2AC01, F_R | F_W | F_A));
    map_pte(pte_addr(L0_PPN, 10'd4), make_pte(22'h2AC02, F_R | F_A));
    map_pte(pte_addr(L0_PPN, 10'd5), make_pte(22'h2AC03, F_R | F_U | F_A));
    map_pte(pte_addr(L0_PPN, 10'd7), make_pte(22'h00300, 8'h00));

    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    translate("bare", $urandom(), 1'b0, PRIV_S, 1'b0, 1'b0, 1'b1);
    // miss fills the DTLB and the repeat hits
    translate("page_4k_miss", 32'h0040_1A5C, 1'b0, PRIV_S, 1'b0, 1'b1, 1'b0);
    translate("page_4k_hit", 32'h0040_1FF0, 1'b1, PRIV_S, 1'b0, 1'b1, 1'b1);
    translate("megapage", 32'h0095_5123, 1'b0, PRIV_S, 1'b0, 1'b1, 1'b0);
    translate("mega_misaligned", 32'h00C0_3000, 1'b0, PRIV_S, 1'b0, 1'b1, 1'b0);
    // permission faults still fill the DTLB
    translate("store_no_w", 32'h0040_2008, 1'b1, PRIV_S, 1'b0, 1'b1, 1'b0);
    translate("store_no_d", 32'h0040_3010, 1'b1, PRIV_S, 1'b0, 1'b1, 1'b0);
    translate("user_on_s_page", 32'h0040_4000, 1'b0, PRIV_U, 1'b0, 1'b1, 1'b0);
    translate("sum_clear", 32'h0040_5444, 1'b0, PRIV_S, 1'b0, 1'b1, 1'b0);
    translate("sum_set", 32'h0040_5444, 1'b0, PRIV_S, 1'b1, 1'b1, 1'b1);
    // walk faults
    translate("pte_invalid_l0", 32'h0040_6000, 1'b0, PRIV_S, 1'b0, 1'b1, 1'b0);
    translate("pte_invalid_l1", 32'h0140_0000, 1'b1, PRIV_S, 1'b0, 1'b1, 1'b0);
    translate("no_levels_left", 32'h0040_7000, 1'b0, PRIV_S, 1'b0, 1'b1, 1'b0);
    translate("load_timeout", 32'h0100_0004, 1'b0, PRIV_S, 1'b0, 1'b1, 1'b0);
    translate("store_timeout", 32'h0100_0008, 1'b1, PRIV_S, 1'b0, 1'b1, 1'b0);
    // flush forces a new walk for a cached page
    translate("hit_before_flush", 32'h0040_5800, 1'b0, PRIV_S, 1'b1, 1'b1, 1'b1);
    flush_dtlb();
    translate("walk_after_flush", 32'h0040_5800, 1'b0, PRIV_S, 1'b1, 1'b1, 1'b0);

    // let the last result pass the checks
    repeat (2) @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
logic/mmu_pkg.sv
logic/sv32_dtlb.sv
logic/sv32_ptw.sv
logic/walk_timer.sv
logic/sv32_perm_check.sv
logic/sv32_mmu.sv
verif/pt_mem_model.sv
verif/tb_sv32_mmu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sv32_mmu testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert \
  --top-module tb_sv32_mmu \
  -f src.f \
  -Mdir "$BUILD_DIR" \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
